// File: hw/jtframe_pkg.sv
/*
 * Board wrapper shared types
 * Joystick layouts for the board and game sides, game and VGA colour
 * structs, and the widths used across the wrapper
 */

package jtframe_pkg;

    // Sample and colour widths
    localparam int SND_W   = 16;
    localparam int GAME_CW = 4;    // Colour bits per channel from the core
    localparam int VGA_CW  = 6;    // Colour bits per channel at the VGA pins

    // Default game reset stretch, in clk_sys cycles
    localparam int RST_CYCLES_DEF = 16;

    // Board joystick, all bits active high
    // right sits at bit 0, pause at bit 9
    typedef struct packed {
        logic       pause;
        logic       coin;
        logic       start;
        logic [2:0] fire;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } board_joy_t;

    // Joystick as the core sees it, polarity set by the wrapper
    typedef struct packed {
        logic [2:0] fire;
        logic       up;
        logic       down;
        logic       left;
        logic       right;
    } game_joy_t;

    // Colour from the core
    typedef struct packed {
        logic [GAME_CW-1:0] r;
        logic [GAME_CW-1:0] g;
        logic [GAME_CW-1:0] b;
    } game_rgb_t;

    // Colour towards the board DAC
    typedef struct packed {
        logic [VGA_CW-1:0] r;
        logic [VGA_CW-1:0] g;
        logic [VGA_CW-1:0] b;
    } vga_rgb_t;

endpackage

// File: hw/board_reset.sv
/*
 * Game reset generator
 * Any of reset, downloading, rst_req or a DIP flip change restarts a
 * down-counter; game_rst stays high until it runs out
 */

`timescale 1ns/100ps

module board_reset #(
    parameter int RST_CYCLES = 16
) (
    input  logic clk_sys,
    input  logic reset,
    input  logic downloading,
    input  logic dip_flip,
    input  logic rst_req,
    output logic game_rst
);

    localparam int CNT_W = $clog2(RST_CYCLES + 1);

    logic             dip_last;
    logic             dip_change;
    logic             trigger;
    logic [CNT_W-1:0] cnt;

    assign dip_change = dip_flip != dip_last;   // Flip setting changed
    assign trigger    = downloading | rst_req | dip_change;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            dip_last <= dip_flip;   // No false change on exit
            cnt      <= CNT_W'(RST_CYCLES);
            game_rst <= 1'b1;
        end else begin
            dip_last <= dip_flip;
            if (trigger) begin
                // Stretch counts from the last trigger cycle
                cnt      <= CNT_W'(RST_CYCLES);
                game_rst <= 1'b1;
            end else begin
                if (cnt != '0)
                    cnt <= cnt - 1'b1;
                game_rst <= cnt != '0;
            end
        end
    end

endmodule

// File: hw/board_inputs.sv
/*
 * Joystick mapping
 * Board joysticks go to the game with the selected polarity, the third
 * fire button masked off if unused, and a pause toggle
 */

`timescale 1ns/100ps

module board_inputs #(
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0
) (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   game_rst,
    input  jtframe_pkg::board_joy_t board_joystick1,
    input  jtframe_pkg::board_joy_t board_joystick2,
    output jtframe_pkg::game_joy_t  game_joystick1,
    output jtframe_pkg::game_joy_t  game_joystick2,
    output logic [1:0]             game_coin,
    output logic [1:0]             game_start,
    output logic                   game_pause
);

    // Level of a released button on the game side
    localparam bit INACTIVE = !GAME_INPUTS_ACTIVE_HIGH;
    localparam int GJ_W     = $bits(jtframe_pkg::game_joy_t);

    logic [1:0] pause_in;
    logic [1:0] pause_last;
    logic       pause_edge;

    function automatic jtframe_pkg::game_joy_t map_joy(input jtframe_pkg::board_joy_t bj);
        jtframe_pkg::game_joy_t gj;
        gj.right = bj.right ^ INACTIVE;
        gj.left  = bj.left  ^ INACTIVE;
        gj.down  = bj.down  ^ INACTIVE;
        gj.up    = bj.up    ^ INACTIVE;
        gj.fire  = bj.fire  ^ {3{INACTIVE}};
        if (!THREE_BUTTONS)
            gj.fire[2] = INACTIVE;  // Two-button games never see fire 3
        return gj;
    endfunction

    assign pause_in   = {board_joystick2.pause, board_joystick1.pause};
    assign pause_edge = |(pause_in & ~pause_last);

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            game_joystick1 <= {GJ_W{INACTIVE}};
            game_joystick2 <= {GJ_W{INACTIVE}};
            game_coin      <= {2{INACTIVE}};
            game_start     <= {2{INACTIVE}};
        end else begin
            game_joystick1 <= map_joy(board_joystick1);
            game_joystick2 <= map_joy(board_joystick2);
            game_coin      <= {board_joystick2.coin, board_joystick1.coin} ^ {2{INACTIVE}};
            game_start     <= {board_joystick2.start, board_joystick1.start} ^ {2{INACTIVE}};
        end
    end

    // Pause toggles once per press from either player
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pause_last <= 2'b00;
        end else begin
            pause_last <= pause_in;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset || game_rst)
            game_pause <= 1'b0;         // A new game starts unpaused
        else if (pause_edge)
            game_pause <= ~game_pause;
    end

endmodule

// File: hw/snd_dac.sv
/*
 * Sound DAC
 * First-order delta-sigma modulator; the carry of a running sum gives
 * a one-bit stream whose density follows the sample
 */

`timescale 1ns/100ps

module snd_dac #(
    parameter bit SIGNED_SND = 1'b0
) (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  logic [jtframe_pkg::SND_W-1:0] snd,
    output logic                         snd_pwm
);

    localparam int W = jtframe_pkg::SND_W;

    logic [W-1:0] sample;   // Offset binary
    logic [W:0]   acc;      // Top bit is the carry of the last add

    // Two's complement to offset binary by flipping the sign bit
    always_comb begin
        sample = snd;
        if (SIGNED_SND)
            sample[W-1] = ~snd[W-1];
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            acc <= '0;
        end else begin
            // Old carry is dropped, only the residue accumulates
            acc <= {1'b0, acc[W-1:0]} + {1'b0, sample};
        end
    end

    assign snd_pwm = acc[W];    // Registered carry out

endmodule

// File: hw/video_out.sv
/*
 * Video output stage
 * Expands 4-bit game colour to 6-bit VGA colour, blanks outside the
 * active area and keeps the syncs aligned with the pixel
 */

`timescale 1ns/100ps

module video_out (
    input  logic                   clk_sys,
    input  logic                   reset,
    input  logic                   pxl_cen,
    input  jtframe_pkg::game_rgb_t game_rgb,
    input  logic                   LHBL,
    input  logic                   LVBL,
    input  logic                   hs,
    input  logic                   vs,
    output jtframe_pkg::vga_rgb_t  vga_rgb,
    output logic                   vga_hs,
    output logic                   vga_vs
);

    localparam int GW = jtframe_pkg::GAME_CW;
    localparam int VW = jtframe_pkg::VGA_CW;

    logic active;

    // Top bits repeated below so full scale maps to full scale
    function automatic logic [VW-1:0] expand(input logic [GW-1:0] c);
        return {c, c[GW-1 -: VW-GW]};
    endfunction

    assign active = LHBL & LVBL;

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            vga_rgb <= '0;
            vga_hs  <= 1'b0;
            vga_vs  <= 1'b0;
        end else if (pxl_cen) begin
            if (active) begin
                vga_rgb.r <= expand(game_rgb.r);
                vga_rgb.g <= expand(game_rgb.g);
                vga_rgb.b <= expand(game_rgb.b);
            end else begin
                vga_rgb <= '0;      // Blanking
            end
            vga_hs <= hs;           // Same delay as colour
            vga_vs <= vs;
        end
    end

endmodule

// File: hw/jtframe_board.sv
/*
 * Board wrapper top level
 * Reset, joystick, sound and video glue between the game core and the
 * board pins, all on clk_sys
 */

`timescale 1ns/100ps

module jtframe_board #(
    parameter bit SIGNED_SND              = 1'b0,
    parameter bit THREE_BUTTONS           = 1'b0,
    parameter bit GAME_INPUTS_ACTIVE_HIGH = 1'b0,
    parameter int RST_CYCLES              = jtframe_pkg::RST_CYCLES_DEF
) (
    input  logic                           clk_sys,
    input  logic                           reset,
    // Reset sources
    input  logic                           downloading,
    input  logic                           dip_flip,
    input  logic                           rst_req,
    output logic                           game_rst,
    // Joysticks
    input  jtframe_pkg::board_joy_t         board_joystick1,
    input  jtframe_pkg::board_joy_t         board_joystick2,
    output logic [6:0]                     game_joystick1,
    output logic [6:0]                     game_joystick2,
    output logic [1:0]                     game_coin,
    output logic [1:0]                     game_start,
    output logic                           game_pause,
    // Sound
    input  logic [jtframe_pkg::SND_W-1:0]   snd,
    output logic                           snd_pwm,
    // Game video
    input  logic                           pxl_cen,
    input  logic [jtframe_pkg::GAME_CW-1:0] game_r,
    input  logic [jtframe_pkg::GAME_CW-1:0] game_g,
    input  logic [jtframe_pkg::GAME_CW-1:0] game_b,
    input  logic                           LHBL,
    input  logic                           LVBL,
    input  logic                           hs,
    input  logic                           vs,
    // VGA
    output logic [jtframe_pkg::VGA_CW-1:0]  VGA_R,
    output logic [jtframe_pkg::VGA_CW-1:0]  VGA_G,
    output logic [jtframe_pkg::VGA_CW-1:0]  VGA_B,
    output logic                           VGA_HS,
    output logic                           VGA_VS
);

    jtframe_pkg::game_rgb_t game_rgb;
    jtframe_pkg::vga_rgb_t  vga_rgb;

    assign game_rgb = {game_r, game_g, game_b};
    assign VGA_R    = vga_rgb.r;
    assign VGA_G    = vga_rgb.g;
    assign VGA_B    = vga_rgb.b;

    board_reset #(.RST_CYCLES(RST_CYCLES)) u_reset (
        .clk_sys        ( clk_sys         ),
        .reset          ( reset           ),
        .downloading    ( downloading     ),
        .dip_flip       ( dip_flip        ),
        .rst_req        ( rst_req         ),
        .game_rst       ( game_rst        )
    );

    board_inputs #(
        .THREE_BUTTONS          ( THREE_BUTTONS           ),
        .GAME_INPUTS_ACTIVE_HIGH( GAME_INPUTS_ACTIVE_HIGH )
    ) u_inputs (
        .clk_sys        ( clk_sys         ),
        .reset          ( reset           ),
        .game_rst       ( game_rst        ),    // Unpauses on game reset
        .board_joystick1( board_joystick1 ),
        .board_joystick2( board_joystick2 ),
        .game_joystick1 ( game_joystick1  ),
        .game_joystick2 ( game_joystick2  ),
        .game_coin      ( game_coin       ),
        .game_start     ( game_start      ),
        .game_pause     ( game_pause      )
    );

    snd_dac #(.SIGNED_SND(SIGNED_SND)) u_dac (
        .clk_sys        ( clk_sys         ),
        .reset          ( reset           ),
        .snd            ( snd             ),
        .snd_pwm        ( snd_pwm         )
    );

    video_out u_video (
        .clk_sys        ( clk_sys         ),
        .reset          ( reset           ),
        .pxl_cen        ( pxl_cen         ),
        .game_rgb       ( game_rgb        ),
        .LHBL           ( LHBL            ),
        .LVBL           ( LVBL            ),
        .hs             ( hs              ),
        .vs             ( vs              ),
        .vga_rgb        ( vga_rgb         ),
        .vga_hs         ( VGA_HS          ),
        .vga_vs         ( VGA_VS          )
    );

endmodule

// File: bench/jtframe_board_assertions.sv
/*
 * Board wrapper assertions
 * Reset request, blanking and pause toggle checks on the top level
 */

`timescale 1ns/100ps

module jtframe_board_assertions (
    input logic                          clk_sys,
    input logic                          reset,
    input logic                          rst_req,
    input logic                          game_rst,
    input logic                          pxl_cen,
    input logic                          LHBL,
    input logic [jtframe_pkg::VGA_CW-1:0] VGA_R,
    input logic [jtframe_pkg::VGA_CW-1:0] VGA_G,
    input logic [jtframe_pkg::VGA_CW-1:0] VGA_B,
    input jtframe_pkg::board_joy_t        board_joystick1,
    input jtframe_pkg::board_joy_t        board_joystick2,
    input logic                          game_pause
);

    int         err_cnt = 0;    // Failed assertions so far
    logic [1:0] pause_in;

    assign pause_in = {board_joystick2.pause, board_joystick1.pause};

    rst_req_a: assert property (@(posedge clk_sys) rst_req |=> game_rst)
        else begin
            $error("game_rst not high in the cycle after rst_req");
            err_cnt++;
        end

    // Blanked pixel shows up black one enable later
    blank_a: assert property (@(posedge clk_sys) disable iff (reset)
        pxl_cen && !LHBL |=> {VGA_R, VGA_G, VGA_B} == '0)
        else begin
            $error("VGA colour not zero after horizontal blanking");
            err_cnt++;
        end

    pause_a: assert property (@(posedge clk_sys) disable iff (reset)
        $changed(game_pause) |-> $past(reset) || $past(game_rst) ||
            (|($past(pause_in) & ~$past(pause_in, 2))))
        else begin
            $error("game_pause changed without a pause edge or reset");
            err_cnt++;
        end

endmodule

bind jtframe_board jtframe_board_assertions u_chk (
    .clk_sys         ( clk_sys         ),
    .reset           ( reset           ),
    .rst_req         ( rst_req         ),
    .game_rst        ( game_rst        ),
    .pxl_cen         ( pxl_cen         ),
    .LHBL            ( LHBL            ),
    .VGA_R           ( VGA_R           ),
    .VGA_G           ( VGA_G           ),
    .VGA_B           ( VGA_B           ),
    .board_joystick1 ( board_joystick1 ),
    .board_joystick2 ( board_joystick2 ),
    .game_pause      ( game_pause      )
);

// File: bench/jtframe_board_tb.sv
/*
 * Board wrapper testbench
 * Runs the vector file through reset stretch, joystick mapping, pause,
 * video and sound density tests on the top level
 */

`timescale 1ns/100ps

module jtframe_board_tb;

    localparam int    TIMEOUT  = 200;   // Cycle limit for any wait
    localparam string VEC_FILE = "bench/board_vectors.txt";

    logic                    clk_sys = 1'b0;
    logic                    reset;
    logic                    downloading;
    logic                    dip_flip;
    logic                    rst_req;
    logic                    game_rst;
    jtframe_pkg::board_joy_t board_joystick1;
    jtframe_pkg::board_joy_t board_joystick2;
    logic [6:0]              game_joystick1;
    logic [6:0]              game_joystick2;
    logic [1:0]              game_coin;
    logic [1:0]              game_start;
    logic                    game_pause;
    logic [15:0]             snd;
    logic                    snd_pwm;
    logic                    pxl_cen;
    logic [3:0]              game_r;
    logic [3:0]              game_g;
    logic [3:0]              game_b;
    logic                    LHBL;
    logic                    LVBL;
    logic                    hs;
    logic                    vs;
    logic [5:0]              VGA_R;
    logic [5:0]              VGA_G;
    logic [5:0]              VGA_B;
    logic                    VGA_HS;
    logic                    VGA_VS;

    int    fld [0:12];      // Fields of the current vector
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    vec_num  = 0;
    logic  test_bad;

    jtframe_board #(
        .SIGNED_SND             ( 1'b1 ),
        .THREE_BUTTONS          ( 1'b0 ),
        .GAME_INPUTS_ACTIVE_HIGH( 1'b0 ),
        .RST_CYCLES             ( 16   )
    ) i_dut (.*);

    always #20 clk_sys = ~clk_sys;

    // Inputs change and outputs are read 2 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #2;
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            test_bad = 1'b1;
        end
    endtask

    task automatic idle_gap();
        int gap;
        gap = $urandom % 4;
        repeat (gap) next_cycle();
    endtask

    task automatic wait_rst_low();
        int n;
        n = 0;
        while (game_rst && n < TIMEOUT) begin
            n++;
            next_cycle();
        end
        if (game_rst) begin
            $display("Timeout: game_rst did not fall within %0d cycles", TIMEOUT);
            test_bad = 1'b1;
        end
    endtask

    // Counts game_rst high cycles from the current one
    task automatic count_rst_high(output int n);
        n = 0;
        while (game_rst && n <= TIMEOUT) begin
            n++;
            next_cycle();
        end
        if (game_rst) begin
            $display("Timeout: game_rst stuck high for over %0d cycles", TIMEOUT);
            test_bad = 1'b1;
        end
    endtask

    task automatic run_reset_vec();
        int n;
        case (fld[0])
            0:       rst_req = 1'b1;
            1:       dip_flip = ~dip_flip;  // Only the change matters
            2:       downloading = 1'b1;
            default: reset = 1'b1;
        endcase
        repeat (fld[1]) next_cycle();
        rst_req     = 1'b0;
        downloading = 1'b0;
        reset       = 1'b0;
        count_rst_high(n);
        check_eq("game_rst high cycles", n, fld[2]);
    endtask

    task automatic run_joy_vec();
        board_joystick1 = fld[0][9:0];
        board_joystick2 = fld[1][9:0];
        next_cycle();
        check_eq("game_joystick1", game_joystick1, fld[2]);
        check_eq("game_joystick2", game_joystick2, fld[3]);
        check_eq("game_coin", game_coin, fld[4]);
        check_eq("game_start", game_start, fld[5]);
    endtask

    task automatic run_pause_vec();
        board_joystick1       = '0;
        board_joystick2       = '0;
        board_joystick1.pause = fld[0][0];
        board_joystick2.pause = fld[1][0];
        rst_req               = fld[2][0];
        next_cycle();
        if (fld[2] != 0) begin
            rst_req = 1'b0;
            wait_rst_low();     // Pause clears while game_rst is high
        end
        check_eq("game_pause", game_pause, fld[3]);
    endtask

    task automatic check_video();
        check_eq("VGA_R", VGA_R, fld[8]);
        check_eq("VGA_G", VGA_G, fld[9]);
        check_eq("VGA_B", VGA_B, fld[10]);
        check_eq("VGA_HS", VGA_HS, fld[11]);
        check_eq("VGA_VS", VGA_VS, fld[12]);
    endtask

    task automatic run_video_vec();
        pxl_cen = fld[0][0];
        game_r  = fld[1][3:0];
        game_g  = fld[2][3:0];
        game_b  = fld[3][3:0];
        LHBL    = fld[4][0];
        LVBL    = fld[5][0];
        hs      = fld[6][0];
        vs      = fld[7][0];
        next_cycle();
        pxl_cen = 1'b0;
        check_video();
        game_r  = ~game_r;      // Inputs move while pxl_cen is low
        game_g  = ~game_g;
        game_b  = ~game_b;
        hs      = ~hs;
        vs      = ~vs;
        next_cycle();
        check_video();          // Outputs hold without a pixel enable
    endtask

    task automatic run_snd_vec();
        int ones;
        int diff;
        snd = fld[0][15:0];
        repeat (64) next_cycle();
        ones = 0;
        repeat (1024) begin
            next_cycle();
            ones += snd_pwm;
        end
        diff = ones - fld[1];
        assert (diff >= -1 && diff <= 1) else begin
            $display("** Error at %0t: snd_pwm ones %0d, expected %0d +/- 1",
                     $time, ones, fld[1]);
            test_bad = 1'b1;
        end
    endtask

    task automatic skip_line(input int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1)
            c = $fgetc(fd);
    endtask

    task automatic report_test(input string tag);
        if (test_bad) begin
            fail_cnt++;
            $display("Test %0d (%s): failed", vec_num, tag);
        end else begin
            pass_cnt++;
            $display("Test %0d (%s): ok", vec_num, tag);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    want;
        string tag;
        void'($urandom(32'ha622_f27f));
        reset           = 1'b1;
        downloading     = 1'b0;
        dip_flip        = 1'b0;
        rst_req         = 1'b0;
        board_joystick1 = '0;
        board_joystick2 = '0;
        snd             = '0;
        pxl_cen         = 1'b0;
        game_r          = '0;
        game_g          = '0;
        game_b          = '0;
        LHBL            = 1'b0;
        LVBL            = 1'b0;
        hs              = 1'b0;
        vs              = 1'b0;
        test_bad        = 1'b0;
        repeat (2) next_cycle();
        reset = 1'b0;
        wait_rst_low();
        if (test_bad)
            fail_cnt++;

        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the vector file %s", VEC_FILE);
            fail_cnt++;
        end else begin
            while ($fscanf(fd, "%s", tag) == 1) begin
                if (tag == "#") begin
                    skip_line(fd);
                    continue;
                end
                case (tag)
                    "R": begin
                        want = 3;
                        n = $fscanf(fd, "%d %d %d", fld[0], fld[1], fld[2]);
                    end
                    "J": begin
                        want = 6;
                        n = $fscanf(fd, "%h %h %h %h %h %h", fld[0], fld[1], fld[2],
                                    fld[3], fld[4], fld[5]);
                    end
                    "P": begin
                        want = 4;
                        n = $fscanf(fd, "%h %h %h %h", fld[0], fld[1], fld[2], fld[3]);
                    end
                    "V": begin
                        want = 13;
                        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6],
                                    fld[7], fld[8], fld[9], fld[10], fld[11], fld[12]);
                    end
                    "S": begin
                        want = 2;
                        n = $fscanf(fd, "%h %d", fld[0], fld[1]);
                    end
                    default: begin
                        want = -1;      // Unknown test tag
                        n    = 0;
                    end
                endcase
                if (n != want) begin
                    $display("Malformed vector line for test tag %s", tag);
                    fail_cnt++;
                    break;
                end
                test_bad = 1'b0;
                vec_num++;
                case (tag)
                    "R":     run_reset_vec();
                    "J":     run_joy_vec();
                    "P":     run_pause_vec();
                    "V":     run_video_vec();
                    default: run_snd_vec();
                endcase
                report_test(tag);
                idle_gap();
            end
            $fclose(fd);
        end

        $display("Tests: %0d passed, %0d failed, %0d assertion failures",
                 pass_cnt, fail_cnt, i_dut.u_chk.err_cnt);
        if (fail_cnt == 0 && vec_num > 0 && i_dut.u_chk.err_cnt == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// File: bench/board_vectors.txt
# R src(0 rst_req 1 dip_flip 2 downloading 3 reset) cycles game_rst_high_count (decimal)
# J joy1 joy2 -> game_joystick1 game_joystick2 game_coin game_start (hex)
# P pause1 pause2 rst_req -> game_pause (hex)
# V cen r g b lhbl lvbl hs vs -> vga_r vga_g vga_b vga_hs vga_vs (hex)
# S snd (hex, signed) -> snd_pwm ones in 1024 cycles (decimal)
R 3 2 17
R 0 1 17
R 1 1 17
R 2 3 17
R 0 4 17
J 000 000 7f 7f 3 3
J 001 002 7e 7d 3 3
J 070 000 4f 7f 3 3
J 100 080 7f 7f 2 1
J 0ff 1ff 40 40 1 0
J 00a 005 75 7a 3 3
J 020 040 5f 7f 3 3
P 1 0 0 1
P 1 0 0 1
P 0 0 0 1
P 0 1 0 0
P 1 1 0 1
P 0 0 1 0
V 1 f 0 8 1 1 1 0 3f 00 22 1 0
V 0 5 a 3 1 1 0 1 3f 00 22 1 0
V 1 5 a 3 1 1 0 1 15 2a 0c 0 1
V 1 c 7 1 0 1 1 1 00 00 00 1 1
V 1 c 7 1 1 0 0 0 00 00 00 0 0
V 0 f f f 1 1 1 1 00 00 00 0 0
V 1 c 7 1 1 1 1 0 33 1d 04 1 0
V 1 f f f 1 1 0 0 3f 3f 3f 0 0
S 0000 512
S 8000 0
S 7fff 1023
S c000 256
S 4000 768
S 0100 516
S ff00 508

// File: src.f
hw/jtframe_pkg.sv
hw/board_reset.sv
hw/board_inputs.sv
hw/snd_dac.sv
hw/video_out.sv
hw/jtframe_board.sv
bench/jtframe_board_assertions.sv
bench/jtframe_board_tb.sv
